//--- hzb_bus_2port.f
rtl/hzb_pkg.sv
rtl/hzb_ahb_port.sv
rtl/hzb_xfer_seq.sv
rtl/hzb_resp_merge.sv
rtl/hzb_bus_2port.sv
verif/tb_clk_gen.sv
verif/tb_ahb_mem.sv
verif/tb_hzb_bus_2port.sv

//--- Bender.yml
package:
  name: hzb_bus_2port

sources:
  # Design, package first
  - rtl/hzb_pkg.sv
  - rtl/hzb_ahb_port.sv
  - rtl/hzb_xfer_seq.sv
  - rtl/hzb_resp_merge.sv
  - rtl/hzb_bus_2port.sv

  # Testbench
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_ahb_mem.sv
      - verif/tb_hzb_bus_2port.sv

//--- verif/tb_hzb_bus_2port.sv
/*
 * Testbench for the dual-port AHB-Lite bus front end
 * Drives commands on both ports, keeps shadow memories and per-port
 * queues of expected responses, checks every merged response
 */

`default_nettype none

module tb_hzb_bus_2port;

	timeunit 1ns;
	timeprecision 100ps;

	import hzb_pkg::*;

	localparam int          DEPTH    = 256;
	localparam int          W_IDX    = $clog2(DEPTH);
	localparam int          N_RAND   = 200;
	localparam int          N_B2B    = 8;
	localparam int          N_CMDS   = 4 + 6 + N_RAND + N_B2B;
	localparam int          WD_LIMIT = N_CMDS * 20 + 200;
	localparam logic [31:0] ERR_BASE = 32'hF000_0000;
	// Word size, single burst, privileged data access, unlocked
	localparam logic [10:0] CTRL_EXP = {3'b010, 3'b000, 4'b0011, 1'b0};

	// Expected response per command
	// chk marks responses whose data is compared
	typedef struct packed {
		logic              err;
		logic              chk;
		logic [W_DATA-1:0] data;
	} exp_rsp_t;

	logic               clk;
	logic               rst_n;
	logic               cmd_strobe;
	xfer_cmd_t          cmd;
	logic [N_PORTS-1:0] port_free;
	ahb_m2s_t           ahb_m [N_PORTS];
	ahb_s2m_t           ahb_s [N_PORTS];
	logic               rsp_valid;
	logic [0:0]         rsp_port;
	logic               rsp_err;
	logic [W_DATA-1:0]  rsp_rdata;

	// Reference model state
	exp_rsp_t           exp_q [N_PORTS][$];
	logic [W_DATA-1:0]  shadow [N_PORTS][DEPTH];
	int                 used [N_PORTS];
	int                 full_seen [N_PORTS];
	integer             seed;
	string              test_name;
	int                 test_errs;
	int                 total_errs;
	int                 tests_run;
	int                 tests_failed;
	logic               idle_check;

	// --------------------------------------------------
	// Clock, DUT and slaves

	tb_clk_gen #(.RST_CYCLES(16)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

	hzb_bus_2port #(
		.W_ADDR      (W_ADDR),
		.W_DATA      (W_DATA),
		.N_PORTS     (N_PORTS)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_strobe_i(cmd_strobe),
		.cmd_i       (cmd),
		.port_free_o (port_free),
		.ahb_m_o     (ahb_m),
		.ahb_s_i     (ahb_s),
		.rsp_valid_o (rsp_valid),
		.rsp_port_o  (rsp_port),
		.rsp_err_o   (rsp_err),
		.rsp_rdata_o (rsp_rdata)
	);

	for (genvar k = 0; k < N_PORTS; k++) begin : g_mem
		tb_ahb_mem #(.SEED(46831 + k), .DEPTH(DEPTH)) i_mem (
			.clk    (clk),
			.rst_n  (rst_n),
			.ahb_m_i(ahb_m[k]),
			.ahb_s_o(ahb_s[k])
		);
	end

	// --------------------------------------------------
	// Response and credit monitor

	// Sampled mid-cycle, where all DUT outputs are settled
	always @(negedge clk) begin
		exp_rsp_t    want;
		int          p;
		logic [10:0] ctrl;
		if (rst_n) begin
			for (int k = 0; k < N_PORTS; k++) begin
				// used mirrors the DUT credit count
				if (used[k] == 2) begin
					full_seen[k]++;
					assert (!port_free[k]) else begin
						$display("%s: port %0d free with two credits in use", test_name, k);
						test_errs++;
					end
				end
				// Fixed control on every NONSEQ
				if (ahb_m[k].htrans == HTRANS_NSEQ) begin
					ctrl = {ahb_m[k].hsize, ahb_m[k].hburst, ahb_m[k].hprot,
						ahb_m[k].hmastlock};
					assert (ctrl == CTRL_EXP) else begin
						$display("Error %s: port %0d control expected %03h actual %03h",
							test_name, k, CTRL_EXP, ctrl);
						test_errs++;
					end
				end
				if (idle_check) begin
					assert (ahb_m[k].htrans == HTRANS_IDLE) else begin
						$display("Error %s: htrans port %0d expected %0h actual %0h",
							test_name, k, HTRANS_IDLE, ahb_m[k].htrans);
						test_errs++;
					end
				end
			end
			if (idle_check) begin
				assert (!rsp_valid) else begin
					$display("Error %s: rsp_valid expected 0 actual 1", test_name);
					test_errs++;
				end
				// Every port free with no command outstanding
				assert (port_free == {N_PORTS{1'b1}}) else begin
					$display("Error %s: port_free expected %0b actual %0b",
						test_name, {N_PORTS{1'b1}}, port_free);
					test_errs++;
				end
			end
			if (cmd_strobe) begin
				used[int'(cmd.port)]++;
			end
			if (rsp_valid) begin
				p = int'(rsp_port);
				used[p]--;
				assert (exp_q[p].size() != 0) else begin
					$display("%s: response on port %0d with no command outstanding",
						test_name, p);
					test_errs++;
				end
				if (exp_q[p].size() != 0) begin
					want = exp_q[p].pop_front();
					assert (rsp_err == want.err) else begin
						$display("Error %s: port %0d err expected %0b actual %0b",
							test_name, p, want.err, rsp_err);
						test_errs++;
					end
					if (want.chk) begin
						assert (rsp_rdata == want.data) else begin
							$display("Error %s: port %0d rdata expected %08h actual %08h",
								test_name, p, want.data, rsp_rdata);
							test_errs++;
						end
					end
				end
			end
		end
	end

	// --------------------------------------------------
	// Helpers

	// Waits for the port, records the expected response, strobes
	task automatic send_cmd(input int port, input cmd_op_e op,
		input logic [W_ADDR-1:0] addr, input logic [W_DATA-1:0] wdata);
		exp_rsp_t         want;
		logic [W_IDX-1:0] idx;
		int               waited;
		waited = 0;
		while (!port_free[port] && waited < 100) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (port_free[port]) else begin
			$display("%s: port %0d stayed busy for 100 cycles", test_name, port);
			test_errs++;
		end
		if (port_free[port]) begin
			idx       = addr[W_IDX+1:2];
			want.err  = (addr >= ERR_BASE);
			want.chk  = (op == OP_READ) && !want.err;
			want.data = shadow[port][idx];
			if (op == OP_WRITE && !want.err) begin
				shadow[port][idx] = wdata;
			end
			exp_q[port].push_back(want);
			cmd_strobe = 1'b1;
			cmd.op     = op;
			cmd.port   = 1'(port);
			cmd.addr   = addr;
			cmd.hsize  = 3'b010;
			cmd.wdata  = wdata;
			@(posedge clk);
			#1;
			cmd_strobe = 1'b0;
		end
	endtask

	// Waits until every expected response has arrived
	task automatic wait_drain();
		int cycles;
		int left;
		cycles = 0;
		left   = exp_q[0].size() + exp_q[1].size();
		while (left != 0 && cycles < 300) begin
			@(posedge clk);
			#1;
			cycles++;
			left = exp_q[0].size() + exp_q[1].size();
		end
		assert (left == 0) else begin
			$display("%s: %0d responses never arrived", test_name, left);
			test_errs++;
		end
		// A few idle cycles to catch duplicates
		repeat (4) @(posedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		for (int k = 0; k < N_PORTS; k++) begin
			full_seen[k] = 0;
		end
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%-14s passed", test_name);
		end else begin
			tests_failed++;
			$display("%-14s fail, %0d errors", test_name, test_errs);
		end
	endtask

	function automatic logic [W_ADDR-1:0] rand_addr();
		logic [W_ADDR-1:0] a;
		a = {22'd0, 8'($random(seed)), 2'b00};
		// About one access in eight hits the error region
		if (($random(seed) & 7) == 0) begin
			a = a | ERR_BASE;
		end
		return a;
	endfunction

	// --------------------------------------------------
	// Watchdog

	initial begin
		repeat (WD_LIMIT) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run stopped", WD_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Tests

	initial begin
		logic [W_DATA-1:0] d;
		seed         = 46831;
		cmd_strobe   = 1'b0;
		cmd          = '0;
		idle_check   = 1'b0;
		test_errs    = 0;
		total_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_name    = "reset";
		for (int k = 0; k < N_PORTS; k++) begin
			used[k]      = 0;
			full_seen[k] = 0;
			// Same fill rule as the slave memory
			for (int i = 0; i < DEPTH; i++) begin
				shadow[k][i] = 32'hC0DE_0000 | 32'(i);
			end
		end
		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;

		// Quiet bus straight after reset
		start_test("idle");
		idle_check = 1'b1;
		repeat (20) @(posedge clk);
		#1;
		idle_check = 1'b0;
		end_test();

		start_test("write_read");
		for (int k = 0; k < N_PORTS; k++) begin
			d = $random(seed);
			send_cmd(k, OP_WRITE, 32'h0000_0040 + 32'(k * 4), d);
			send_cmd(k, OP_READ, 32'h0000_0040 + 32'(k * 4), 32'd0);
		end
		wait_drain();
		end_test();

		// Error region aliases word 4 in the slave
		start_test("error_region");
		for (int k = 0; k < N_PORTS; k++) begin
			send_cmd(k, OP_WRITE, ERR_BASE | 32'h10, 32'hDEAD_BEEF);
			send_cmd(k, OP_READ, ERR_BASE | 32'h10, 32'd0);
			send_cmd(k, OP_READ, 32'h0000_0010, 32'd0);
		end
		wait_drain();
		end_test();

		start_test("random_mix");
		for (int n = 0; n < N_RAND; n++) begin
			send_cmd($random(seed) & 1, ($random(seed) & 1) ? OP_WRITE : OP_READ,
				rand_addr(), $random(seed));
		end
		wait_drain();
		end_test();

		start_test("back_to_back");
		for (int n = 0; n < N_B2B; n++) begin
			send_cmd(0, n[0] ? OP_READ : OP_WRITE, 32'h0000_0080, $random(seed));
		end
		wait_drain();
		assert (full_seen[0] > 0) else begin
			$display("%s: port 0 never reached two credits in use", test_name);
			test_errs++;
		end
		end_test();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
		if (total_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_ahb_mem.sv
/*
 * AHB-Lite slave memory model
 * Word memory with 0 to 3 random wait states per transfer and a
 * two-cycle ERROR response at and above the error base address
 */

`default_nettype none

module tb_ahb_mem #(
	parameter int SEED  = 46831,
	parameter int DEPTH = 256
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire hzb_pkg::ahb_m2s_t ahb_m_i,
	output hzb_pkg::ahb_s2m_t      ahb_s_o
);

	timeunit 1ns;
	timeprecision 100ps;

	import hzb_pkg::*;

	localparam int          W_IDX    = $clog2(DEPTH);
	localparam logic [31:0] ERR_BASE = 32'hF000_0000;

	logic [31:0]      mem [DEPTH];
	integer           seed = SEED;
	logic             busy_q;
	logic [1:0]       wait_q;
	// 2 first ERROR cycle, 1 second ERROR cycle, 0 OKAY
	logic [1:0]       err_q;
	logic [W_IDX-1:0] idx_q;
	logic             write_q;
	logic             hready;
	logic             hresp;

	// --------------------------------------------------
	// Response signals

	always_comb begin
		hready = 1'b1;
		hresp  = 1'b0;
		if (busy_q) begin
			if (wait_q != 2'd0) begin
				hready = 1'b0;
			end else if (err_q == 2'd2) begin
				hready = 1'b0;
				hresp  = 1'b1;
			end else if (err_q == 2'd1) begin
				hresp = 1'b1;
			end
		end
		ahb_s_o.hready = hready;
		ahb_s_o.hresp  = hresp;
		ahb_s_o.hrdata = (busy_q && !write_q) ? mem[idx_q] : '0;
	end

	// --------------------------------------------------
	// Data phase tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			wait_q  <= 2'd0;
			err_q   <= 2'd0;
			idx_q   <= '0;
			write_q <= 1'b0;
		end else begin
			// Count down waits, then step through ERROR
			if (busy_q && wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else if (busy_q && err_q == 2'd2) begin
				err_q <= 2'd1;
			end
			// New address phase on any hready-high cycle
			if (hready) begin
				busy_q <= (ahb_m_i.htrans == HTRANS_NSEQ);
				if (ahb_m_i.htrans == HTRANS_NSEQ) begin
					idx_q   <= ahb_m_i.haddr[W_IDX+1:2];
					write_q <= ahb_m_i.hwrite;
					wait_q  <= 2'($random(seed));
					err_q   <= (ahb_m_i.haddr >= ERR_BASE) ? 2'd2 : 2'd0;
				end
			end
		end
	end

	// --------------------------------------------------
	// Storage

	// Filled with a per-word pattern while reset is held
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= 32'hC0DE_0000 | 32'(i);
			end
		end else if (busy_q && hready && write_q && err_q == 2'd0) begin
			mem[idx_q] <= ahb_m_i.hwdata;
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 10 ns clock, active-low reset held for a set number of cycles
 */

`default_nettype none

module tb_clk_gen #(
	parameter int RST_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_n_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// Release just after a rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/hzb_bus_2port.sv
/*
 * Dual-port AHB-Lite bus front end, top level
 * Sequencer, one bridge per port and the response merger
 */

`default_nettype none

module hzb_bus_2port #(
	parameter int W_ADDR  = hzb_pkg::W_ADDR,
	parameter int W_DATA  = hzb_pkg::W_DATA,
	parameter int N_PORTS = hzb_pkg::N_PORTS
) (
	input  wire                        clk,
	input  wire                        rst_n,

	// Commands
	input  wire                        cmd_strobe_i,
	input  wire hzb_pkg::xfer_cmd_t    cmd_i,
	output logic [N_PORTS-1:0]         port_free_o,

	// AHB-Lite master ports
	output hzb_pkg::ahb_m2s_t          ahb_m_o [N_PORTS],
	input  wire hzb_pkg::ahb_s2m_t     ahb_s_i [N_PORTS],

	// Responses
	output logic                       rsp_valid_o,
	output logic [$clog2(N_PORTS)-1:0] rsp_port_o,
	output logic                       rsp_err_o,
	output logic [W_DATA-1:0]          rsp_rdata_o
);

	import hzb_pkg::*;

	// Sequencer to bridges
	xfer_req_t          req [N_PORTS];
	logic [N_PORTS-1:0] aph_ready;
	// Bridges to merger
	xfer_rsp_t          rsp [N_PORTS];
	// Merger credit return
	logic [N_PORTS-1:0] pop;

	// ------------------------------------------------
	// Sequencer

	hzb_xfer_seq #(
		.N_PORTS     (N_PORTS)
	) i_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_strobe_i(cmd_strobe_i),
		.cmd_i       (cmd_i),
		.port_free_o (port_free_o),
		.req_o       (req),
		.aph_ready_i (aph_ready),
		.pop_i       (pop)
	);

	// ------------------------------------------------
	// Port bridges

	for (genvar k = 0; k < N_PORTS; k++) begin : g_port
		hzb_ahb_port #(
			.W_ADDR     (W_ADDR),
			.W_DATA     (W_DATA)
		) i_port (
			.clk        (clk),
			.rst_n      (rst_n),
			.req_i      (req[k]),
			.aph_ready_o(aph_ready[k]),
			.rsp_o      (rsp[k]),
			.ahb_m_o    (ahb_m_o[k]),
			.ahb_s_i    (ahb_s_i[k])
		);
	end

	// ------------------------------------------------
	// Response merger

	hzb_resp_merge #(
		.N_PORTS    (N_PORTS),
		.W_DATA     (W_DATA)
	) i_merge (
		.clk        (clk),
		.rst_n      (rst_n),
		.rsp_i      (rsp),
		.pop_o      (pop),
		.rsp_valid_o(rsp_valid_o),
		.rsp_port_o (rsp_port_o),
		.rsp_err_o  (rsp_err_o),
		.rsp_rdata_o(rsp_rdata_o)
	);

endmodule

`default_nettype wire

//--- rtl/hzb_resp_merge.sv
/*
 * Response merger
 * Two-entry completion FIFO per port, drained one entry per cycle
 * in round-robin order into a single response stream
 */

`default_nettype none

module hzb_resp_merge #(
	parameter int N_PORTS = hzb_pkg::N_PORTS,
	parameter int W_DATA  = hzb_pkg::W_DATA
) (
	input  wire                             clk,
	input  wire                             rst_n,

	// Completions from the bridges
	input  wire hzb_pkg::xfer_rsp_t         rsp_i [N_PORTS],

	// Credit return
	output logic [N_PORTS-1:0]              pop_o,

	// Merged response stream
	output logic                            rsp_valid_o,
	output logic [$clog2(N_PORTS)-1:0]      rsp_port_o,
	output logic                            rsp_err_o,
	output logic [W_DATA-1:0]               rsp_rdata_o
);

	import hzb_pkg::*;

	localparam int W_PORT = $clog2(N_PORTS);

	logic [N_PORTS-1:0] not_empty;
	logic [W_DATA:0]    head [N_PORTS];
	logic [W_PORT-1:0]  prio_q;
	logic [W_PORT-1:0]  sel_idx;
	logic               sel_vld;

	// ------------------------------------------------
	// Per-port FIFOs

	for (genvar k = 0; k < N_PORTS; k++) begin : g_fifo

		logic [W_DATA:0] mem_q [2];
		logic [1:0]      cnt_q;
		logic            wr_ptr_q;
		logic            rd_ptr_q;

		// Entry is {err, rdata}
		always_ff @(posedge clk) begin
			if (rsp_i[k].done) begin
				mem_q[wr_ptr_q] <= {rsp_i[k].err, rsp_i[k].rdata};
			end
		end

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt_q    <= 2'd0;
				wr_ptr_q <= 1'b0;
				rd_ptr_q <= 1'b0;
			end else begin
				if (rsp_i[k].done) begin
					wr_ptr_q <= !wr_ptr_q;
				end
				if (pop_o[k]) begin
					rd_ptr_q <= !rd_ptr_q;
				end
				case ({rsp_i[k].done, pop_o[k]})
					2'b10: cnt_q <= cnt_q + 2'd1;
					2'b01: cnt_q <= cnt_q - 2'd1;
					default: cnt_q <= cnt_q;
				endcase
			end
		end

		assign not_empty[k] = (cnt_q != 2'd0);
		assign head[k]      = mem_q[rd_ptr_q];

		// Credit limit keeps each FIFO from overflowing
		a_no_overflow: assert property (
			@(posedge clk) disable iff (!rst_n)
			rsp_i[k].done |-> (cnt_q != 2'd2)
		) else $error("hzb_resp_merge: push into full FIFO on port %0d", k);

	end

	// ------------------------------------------------
	// Round-robin select

	// Scan from prio_q upward, nearest non-empty port wins
	always_comb begin
		int cand;
		sel_vld = 1'b0;
		sel_idx = prio_q;
		for (int i = N_PORTS - 1; i >= 0; i--) begin
			cand = (int'(prio_q) + i) % N_PORTS;
			if (not_empty[cand]) begin
				sel_vld = 1'b1;
				sel_idx = W_PORT'(cand);
			end
		end
	end

	// Granted port drops to lowest priority
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_q <= '0;
		end else if (sel_vld) begin
			prio_q <= (sel_idx == W_PORT'(N_PORTS - 1)) ? '0 : sel_idx + 1'b1;
		end
	end

	always_comb begin
		pop_o = '0;
		if (sel_vld) begin
			pop_o[sel_idx] = 1'b1;
		end
	end

	// Output straight from the selected FIFO head
	assign rsp_valid_o = sel_vld;
	assign rsp_port_o  = sel_idx;
	assign rsp_err_o   = head[sel_idx][W_DATA];
	assign rsp_rdata_o = head[sel_idx][W_DATA-1:0];

endmodule

`default_nettype wire

//--- rtl/hzb_xfer_seq.sv
/*
 * Transfer sequencer
 * Takes command strobes, holds one pending address-phase request
 * per port and counts in-flight credits up to two per port
 */

`default_nettype none

module hzb_xfer_seq #(
	parameter int N_PORTS = hzb_pkg::N_PORTS
) (
	input  wire                     clk,
	input  wire                     rst_n,

	// Command input
	input  wire                     cmd_strobe_i,
	input  wire hzb_pkg::xfer_cmd_t cmd_i,
	output logic [N_PORTS-1:0]      port_free_o,

	// Bridge side
	output hzb_pkg::xfer_req_t      req_o [N_PORTS],
	input  wire [N_PORTS-1:0]       aph_ready_i,

	// Credit return from the merger
	input  wire [N_PORTS-1:0]       pop_i
);

	import hzb_pkg::*;

	// Two transfers per port between accept and pop
	localparam logic [1:0] MAX_CREDITS = 2'd2;

	logic [N_PORTS-1:0] accept;

	for (genvar k = 0; k < N_PORTS; k++) begin : g_port

		logic              pend_vld_q;
		logic [1:0]        used_q;
		logic [W_ADDR-1:0] addr_q;
		logic [2:0]        hsize_q;
		logic              write_q;
		logic [W_DATA-1:0] wdata_q;

		// Strobe addressed to this port
		assign accept[k] = cmd_strobe_i && (int'(cmd_i.port) == k);

		// ------------------------------------------------
		// Pending request

		// Set by a strobe, cleared by the bridge's acceptance
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				pend_vld_q <= 1'b0;
			end else if (accept[k]) begin
				pend_vld_q <= 1'b1;
			end else if (aph_ready_i[k]) begin
				pend_vld_q <= 1'b0;
			end
		end

		// Payload of the pending request
		always_ff @(posedge clk) begin
			if (accept[k]) begin
				addr_q  <= cmd_i.addr;
				hsize_q <= cmd_i.hsize;
				write_q <= (cmd_i.op == OP_WRITE);
				wdata_q <= cmd_i.wdata;
			end
		end

		always_comb begin
			req_o[k].req   = pend_vld_q;
			req_o[k].addr  = addr_q;
			req_o[k].hsize = hsize_q;
			req_o[k].write = write_q;
			req_o[k].wdata = wdata_q;
		end

		// ------------------------------------------------
		// Credits

		// Taken at accept, returned when the merger pops
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				used_q <= 2'd0;
			end else begin
				case ({accept[k], pop_i[k]})
					2'b10: used_q <= used_q + 2'd1;
					2'b01: used_q <= used_q - 2'd1;
					default: used_q <= used_q;
				endcase
			end
		end

		// Free when no request waits and a credit remains
		assign port_free_o[k] = !pend_vld_q && (used_q != MAX_CREDITS);

		// ------------------------------------------------
		// Checks

		// A pop always matches an earlier accepted command
		a_no_underflow: assert property (
			@(posedge clk) disable iff (!rst_n)
			pop_i[k] |-> (used_q != 2'd0)
		) else $error("hzb_xfer_seq: pop with no credit in use on port %0d", k);

	end

	// Sender honours port_free_o
	a_strobe_free: assert property (
		@(posedge clk) disable iff (!rst_n)
		cmd_strobe_i |-> port_free_o[cmd_i.port]
	) else $error("hzb_xfer_seq: strobe to busy port %0d", cmd_i.port);

endmodule

`default_nettype wire

//--- rtl/hzb_ahb_port.sv
/*
 * AHB-Lite master port bridge
 * Turns a split address/data-phase request into NONSEQ or IDLE,
 * tracks the data phase and reports ready, done and error
 */

`default_nettype none

module hzb_ahb_port #(
	parameter int W_ADDR = hzb_pkg::W_ADDR,
	parameter int W_DATA = hzb_pkg::W_DATA
) (
	input  wire                    clk,
	input  wire                    rst_n,

	// Sequencer side
	input  wire hzb_pkg::xfer_req_t req_i,
	output logic                   aph_ready_o,

	// Completion toward the merger
	output hzb_pkg::xfer_rsp_t     rsp_o,

	// AHB-Lite master port
	output hzb_pkg::ahb_m2s_t      ahb_m_o,
	input  wire hzb_pkg::ahb_s2m_t ahb_s_i
);

	import hzb_pkg::*;

	// Single transfers only
	localparam logic [2:0] HBURST_SINGLE = 3'b000;
	// Data access, privileged, not bufferable, not cacheable
	localparam logic [3:0] HPROT_DATA    = 4'b0011;

	logic              hready;
	logic              dphase_active_q;
	logic [W_ADDR-1:0] aph_addr;
	logic [W_DATA-1:0] wdata_q;

	assign hready   = ahb_s_i.hready;
	assign aph_addr = req_i.addr;

	// ------------------------------------------------
	// Address phase

	// Request accepted on the first hready-high cycle
	assign aph_ready_o = hready && req_i.req;

	// Data phase follows an accepted NONSEQ
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dphase_active_q <= 1'b0;
		end else if (hready) begin
			dphase_active_q <= req_i.req;
		end
	end

	// Write data captured at acceptance
	// held for the whole data phase
	always_ff @(posedge clk) begin
		if (aph_ready_o) begin
			wdata_q <= req_i.wdata;
		end
	end

	// ------------------------------------------------
	// Bus outputs

	always_comb begin
		ahb_m_o.haddr     = aph_addr;
		ahb_m_o.hwrite    = req_i.write;
		ahb_m_o.htrans    = req_i.req ? HTRANS_NSEQ : HTRANS_IDLE;
		ahb_m_o.hsize     = req_i.hsize;
		// Fixed control, no bursts and no locking
		ahb_m_o.hburst    = HBURST_SINGLE;
		ahb_m_o.hprot     = HPROT_DATA;
		ahb_m_o.hmastlock = 1'b0;
		ahb_m_o.hwdata    = wdata_q;
	end

	// ------------------------------------------------
	// Data phase completion

	// Done on the closing hready cycle of a live data phase
	// err only on the second cycle of an ERROR response
	always_comb begin
		rsp_o.done  = hready && dphase_active_q;
		rsp_o.err   = hready && dphase_active_q && ahb_s_i.hresp;
		rsp_o.rdata = ahb_s_i.hrdata;
	end

	// ------------------------------------------------
	// Checks

	// Sequencer must hold the request while the slave stalls
	property p_aph_hold;
		@(posedge clk) disable iff (!rst_n)
		(ahb_m_o.htrans == HTRANS_NSEQ && !hready)
			|=> ($stable(ahb_m_o.haddr) && $stable(ahb_m_o.htrans));
	endproperty

	a_aph_hold: assert property (p_aph_hold)
		else $error("hzb_ahb_port: address phase changed under wait state");

endmodule

`default_nettype wire

//--- rtl/hzb_pkg.sv
/*
 * Shared types for the dual-port AHB-Lite bus front end
 * Widths, command opcode, transfer type, and the structs that carry
 * commands, core-side requests, completions and AHB-Lite signals
 */

`default_nettype none

package hzb_pkg;

	// Default widths, overridden through module parameters
	localparam int W_ADDR  = 32;
	localparam int W_DATA  = 32;
	localparam int N_PORTS = 2;

	// ------------------------------------------------
	// Enums

	// Command opcode from the outside
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} cmd_op_e;

	// AHB-Lite HTRANS, only the two codes this master uses
	typedef enum logic [1:0] {
		HTRANS_IDLE = 2'b00,
		HTRANS_NSEQ = 2'b10
	} htrans_e;

	// ------------------------------------------------
	// Structs

	// Transfer command, 69 bits
	typedef struct packed {
		cmd_op_e           op;
		logic              port;
		logic [W_ADDR-1:0] addr;
		logic [2:0]        hsize;
		logic [W_DATA-1:0] wdata;
	} xfer_cmd_t;

	// Core-style address-phase request toward one bridge, 69 bits
	typedef struct packed {
		logic              req;
		logic [W_ADDR-1:0] addr;
		logic [2:0]        hsize;
		logic              write;
		logic [W_DATA-1:0] wdata;
	} xfer_req_t;

	// Data-phase completion, 34 bits
	typedef struct packed {
		logic              done;
		logic              err;
		logic [W_DATA-1:0] rdata;
	} xfer_rsp_t;

	// AHB-Lite master outputs
	typedef struct packed {
		logic [W_ADDR-1:0] haddr;
		logic              hwrite;
		htrans_e           htrans;
		logic [2:0]        hsize;
		logic [2:0]        hburst;
		logic [3:0]        hprot;
		logic              hmastlock;
		logic [W_DATA-1:0] hwdata;
	} ahb_m2s_t;

	// AHB-Lite slave returns, 34 bits
	typedef struct packed {
		logic              hready;
		logic              hresp;
		logic [W_DATA-1:0] hrdata;
	} ahb_s2m_t;

endpackage

`default_nettype wire
